//--- tb.f
mips_pkg.sv
pipe_reg.sv
hazard_unit.sv
forward_unit.sv
operand_select.sv
alu.sv
next_pc_select.sv
ex_stage_top.sv
ex_stage_properties.sv
tb_ex_stage.sv

//--- run.sh
#!/bin/sh
# compile and run the execute-stage testbench with Verilator
rm -f sim.log build.log && \
verilator --binary --timing --assert -Wno-fatal --top-module tb_ex_stage \
	-f tb.f -o sim_ex_stage > build.log 2>&1 && \
./obj_dir/sim_ex_stage > sim.log 2>&1
grep -qx '>>> PASS' sim.log && echo "simulation passed" || \
	{ echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- tb_ex_stage.sv
// directed testbench for the MIPS execute stage
// plays decode on id_in and MEM/WB on wb_fwd, checks results, forwarding, stalls and redirects
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage import mips_pkg::*; ();

	logic      clk;
	logic      arst_n;
	id_ex_t    id_in;
	wb_fwd_t   wb_fwd;
	logic      stall;
	redirect_t redirect;
	ex_mem_t   ex_mem_out;
	ex_mem_t   wb_q;
	int        errors = 0;
	// register value that must be bypassed
	logic [31:0] stale = 32'hdead_beef;

	ex_stage_top UUT (
		.clk        (clk),
		.arst_n     (arst_n),
		.id_in      (id_in),
		.wb_fwd     (wb_fwd),
		.stall      (stall),
		.redirect   (redirect),
		.ex_mem_out (ex_mem_out)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// data memory contents as a pattern over the whole address
	function automatic logic [31:0] mem_word(logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ 32'h3c3c_0f0f;
	endfunction

	// MEM/WB stage model
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_q <= '0;
		end else begin
			wb_q <= ex_mem_out;
		end
	end

	// loads return memory data and everything else its result
	assign wb_fwd = '{
		reg_write: wb_q.valid && wb_q.reg_write,
		dest:      wb_q.dest,
		data:      wb_q.mem_to_reg ? mem_word(wb_q.result) : wb_q.result
	};

	// reference ALU
	function automatic logic [31:0] alu_model(alu_op_e op, logic [31:0] a, logic [31:0] b);
		case (op)
			alu_add: return a + b;
			alu_sub: return a - b;
			alu_and: return a & b;
			alu_or:  return a | b;
			alu_xor: return a ^ b;
			alu_nor: return ~(a | b);
			alu_slt: return {31'd0, $signed(a) < $signed(b)};
			default: return 32'd0;
		endcase
	endfunction

	function automatic logic [31:0] sext16(logic [31:0] r);
		return {{16{r[15]}}, r[15:0]};
	endfunction

	function automatic id_ex_t r_type(alu_op_e op, logic [4:0] rs, logic [4:0] rt,
			logic [4:0] rd, logic [31:0] rs_data, logic [31:0] rt_data);
		id_ex_t b;
		b = '0;
		b.valid = 1'b1;
		b.ctrl.reg_write = 1'b1;
		b.ctrl.reg_dst = reg_dst_rd;
		b.ctrl.alu_op = op;
		b.rs = rs;
		b.rt = rt;
		b.rd = rd;
		b.rs_data = rs_data;
		b.rt_data = rt_data;
		return b;
	endfunction

	// immediate form writes rt
	function automatic id_ex_t i_type(alu_op_e op, logic [4:0] rs, logic [4:0] rt,
			logic [31:0] rs_data, logic [31:0] imm);
		id_ex_t b;
		b = r_type(op, rs, rt, 5'd0, rs_data, 32'd0);
		b.ctrl.reg_dst = reg_dst_rt;
		b.ctrl.alu_src = 1'b1;
		b.imm = imm;
		return b;
	endfunction

	task automatic check_eq(string name, logic [31:0] exp, logic [31:0] act);
		assert (act === exp) else begin
			errors++;
			$display("** Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic issue(id_ex_t b);
		@(negedge clk);
		id_in = b;
	endtask

	// last issued instruction reaches ex_mem_out two edges later
	task automatic finish_check(string name, logic [4:0] dest, logic [31:0] result);
		issue('0);
		@(negedge clk);
		check_eq({name, " valid"}, 32'd1, 32'(ex_mem_out.valid));
		check_eq({name, " dest"}, 32'(dest), 32'(ex_mem_out.dest));
		check_eq({name, " result"}, result, ex_mem_out.result);
	endtask

	task automatic idle_check(string name);
		check_eq({name, " valid"}, 32'd0, 32'(ex_mem_out.valid));
		check_eq({name, " write enables"}, 32'd0, 32'({ex_mem_out.reg_write,
			ex_mem_out.mem_read, ex_mem_out.mem_write}));
		check_eq({name, " taken"}, 32'd0, 32'(redirect.taken));
		check_eq({name, " stall"}, 32'd0, 32'(stall));
	endtask

	// every ALU op as R-type then immediate on registers that never collide
	task automatic plain_exec();
		logic [31:0] a;
		logic [31:0] b;
		alu_op_e     op;
		for (int i = 0; i < 7; i++) begin
			op = alu_op_e'(i);
			a = $urandom();
			b = $urandom();
			issue(r_type(op, 5'd3, 5'd4, 5'd5, a, b));
			finish_check("plain_r", 5'd5, alu_model(op, a, b));
			b = sext16($urandom());
			issue(i_type(op, 5'd1, 5'd2, a, b));
			finish_check("plain_i", 5'd2, alu_model(op, a, b));
		end
	endtask

	task automatic forwarding();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		id_ex_t      st;
		a = $urandom();
		b = $urandom();
		c = $urandom();
		// back to back takes the EX/MEM value
		issue(r_type(alu_add, 5'd1, 5'd3, 5'd6, a, b));
		issue(r_type(alu_sub, 5'd6, 5'd7, 5'd9, stale, c));
		finish_check("fwd_ex_mem", 5'd9, (a + b) - c);
		// one apart takes the MEM/WB value
		issue(r_type(alu_or, 5'd1, 5'd3, 5'd10, a, b));
		issue(r_type(alu_add, 5'd1, 5'd3, 5'd11, a, b));
		issue(r_type(alu_xor, 5'd4, 5'd10, 5'd12, c, stale));
		finish_check("fwd_mem_wb", 5'd12, c ^ (a | b));
		// when both stages match the newer one wins
		issue(r_type(alu_add, 5'd1, 5'd3, 5'd13, a, b));
		issue(r_type(alu_and, 5'd1, 5'd3, 5'd13, a, b));
		issue(r_type(alu_add, 5'd13, 5'd4, 5'd14, stale, c));
		finish_check("fwd_priority", 5'd14, (a & b) + c);
		// store data is the forwarded rt while the ALU adds the offset
		issue(r_type(alu_xor, 5'd1, 5'd3, 5'd15, a, b));
		st = i_type(alu_add, 5'd4, 5'd15, c, 32'd4);
		st.ctrl.reg_write = 1'b0;
		st.ctrl.mem_write = 1'b1;
		issue(st);
		finish_check("fwd_store", 5'd15, c + 32'd4);
		check_eq("fwd_store data", a ^ b, ex_mem_out.store_data);
		check_eq("fwd_store write", 32'd1, 32'(ex_mem_out.mem_write));
		// writes to $zero in both stages
		issue(r_type(alu_add, 5'd1, 5'd3, 5'd0, a, b));
		issue(r_type(alu_add, 5'd1, 5'd3, 5'd0, a, b));
		issue(r_type(alu_or, 5'd0, 5'd4, 5'd16, 32'd0, c));
		finish_check("fwd_zero", 5'd16, c);
	endtask

	task automatic load_use();
		id_ex_t      ld;
		id_ex_t      dep;
		logic [31:0] base;
		logic [31:0] v;
		base = $urandom() & 32'hffff_fff0;
		v = $urandom();
		ld = i_type(alu_add, 5'd17, 5'd18, base, 32'd8);
		ld.ctrl.mem_read = 1'b1;
		ld.ctrl.mem_to_reg = 1'b1;
		dep = r_type(alu_add, 5'd18, 5'd19, 5'd20, stale, v);
		issue(ld);
		issue(dep);
		#1;
		check_eq("load_use stall", 32'd1, 32'(stall));
		// decode holds the dependent instruction for one cycle
		issue(dep);
		#1;
		check_eq("load_use release", 32'd0, 32'(stall));
		// the load itself sits in EX/MEM while the bubble is in EX
		check_eq("load_use load flags", 32'b11101, 32'({ex_mem_out.valid,
			ex_mem_out.reg_write, ex_mem_out.mem_read, ex_mem_out.mem_write,
			ex_mem_out.mem_to_reg}));
		issue('0);
		check_eq("load_use bubble", 32'd0, 32'(ex_mem_out.valid));
		@(negedge clk);
		check_eq("load_use dest", 32'd20, 32'(ex_mem_out.dest));
		check_eq("load_use result", mem_word(base + 32'd8) + v, ex_mem_out.result);
	endtask

	// control instruction followed by a wrong-path candidate
	task automatic flow_check(string name, id_ex_t c, logic taken, logic [31:0] target);
		issue(c);
		issue(r_type(alu_or, 5'd1, 5'd3, 5'd22, 32'h1, 32'h2));
		#1;
		check_eq({name, " taken"}, 32'(taken), 32'(redirect.taken));
		if (taken) begin
			check_eq({name, " target"}, target, redirect.target);
		end
		issue('0);
		check_eq({name, " valid"}, 32'd1, 32'(ex_mem_out.valid));
		if (c.ctrl.jal) begin
			check_eq({name, " link dest"}, 32'd31, 32'(ex_mem_out.dest));
			check_eq({name, " link"}, c.pc_plus_4, ex_mem_out.result);
		end
		@(negedge clk);
		check_eq({name, " wrong path"}, 32'(!taken), 32'(ex_mem_out.valid));
	endtask

	task automatic control_flow();
		id_ex_t      c;
		logic [31:0] x;
		logic [31:0] pc;
		logic [31:0] imm;
		logic [31:0] tgt;
		x = $urandom();
		pc = $urandom() & 32'hffff_fffc;
		imm = sext16($urandom());
		c = r_type(alu_sub, 5'd1, 5'd3, 5'd0, x, x);
		c.ctrl.reg_write = 1'b0;
		c.pc_plus_4 = pc;
		c.imm = imm;
		c.ctrl.branch = br_beq;
		flow_check("beq_taken", c, 1'b1, pc + (imm << 2));
		c.ctrl.branch = br_bne;
		flow_check("bne_not_taken", c, 1'b0, pc);
		c.rt_data = x ^ 32'h1;
		flow_check("bne_taken", c, 1'b1, pc + (imm << 2));
		c.ctrl.branch = br_beq;
		flow_check("beq_not_taken", c, 1'b0, pc);
		c.ctrl.branch = br_none;
		c.jump_index = 26'($urandom());
		c.ctrl.jump = 1'b1;
		// region of pc+4 with the word index shifted in below it
		tgt = (pc & 32'hf000_0000) | (32'(c.jump_index) << 2);
		flow_check("j", c, 1'b1, tgt);
		c.ctrl.jump = 1'b0;
		c.ctrl.jal = 1'b1;
		c.ctrl.reg_write = 1'b1;
		c.ctrl.reg_dst = reg_dst_ra;
		flow_check("jal", c, 1'b1, tgt);
		// jr target comes from the instruction right before it
		tgt = $urandom() & 32'hffff_fffc;
		issue(i_type(alu_or, 5'd0, 5'd21, 32'd0, tgt));
		c = '0;
		c.valid = 1'b1;
		c.ctrl.jr = 1'b1;
		c.rs = 5'd21;
		c.rs_data = stale;
		flow_check("jr", c, 1'b1, tgt);
	endtask

	initial begin
		void'($urandom(32'h05355dd3));
		arst_n = 1'b0;
		id_in = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		idle_check("reset_hold");
		arst_n = 1'b1;
		@(negedge clk);
		idle_check("reset_release");
		plain_exec();
		forwarding();
		load_use();
		control_flow();
		$display("errors: %0d checks, %0d assertions", errors, UUT.u_props.fail_count);
		if (errors == 0 && UUT.u_props.fail_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// reset, 14 plain ops, forwarding, load-use, 7 control cases, plus margin
	initial begin
		int cycles;
		cycles = 5 + 14 * 3 + 24 + 5 + 7 * 4 + 1;
		#((cycles + 100) * 4);
		$display("timeout: the tests did not finish in time");
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- ex_stage_properties.sv
// concurrent checks on the execute stage
// bound onto the top level, sampled at the rising clock edge
`timescale 1ns/1ps
`default_nettype none

module ex_stage_properties import mips_pkg::*; (
	input wire logic      clk,
	input wire logic      arst_n,
	input wire logic      stall,
	input wire redirect_t redirect,
	input wire ex_mem_t   ex_mem_out,
	input wire id_ex_t    ex_in
);

	int unsigned fail_count = 0;

	// a redirect drops the wrong-path instruction instead of holding it
	no_stall_in_redirect: assert property (@(posedge clk) disable iff (!arst_n)
		redirect.taken |-> !stall)
	else begin
		fail_count++;
		$error("stall high while a redirect is taken");
	end

	// load and store never share one slot
	single_mem_access: assert property (@(posedge clk) disable iff (!arst_n)
		!(ex_mem_out.mem_read && ex_mem_out.mem_write))
	else begin
		fail_count++;
		$error("EX/MEM holds both a read and a write");
	end

	// a stall leaves a bubble in EX
	bubble_after_stall: assert property (@(posedge clk) disable iff (!arst_n)
		stall |=> !ex_in.valid)
	else begin
		fail_count++;
		$error("valid instruction in EX right after a stall");
	end

endmodule

bind ex_stage_top ex_stage_properties u_props (
	.clk        (clk),
	.arst_n     (arst_n),
	.stall      (stall),
	.redirect   (redirect),
	.ex_mem_out (ex_mem_out),
	.ex_in      (ex_in)
);

`default_nettype wire

//--- ex_stage_top.sv
// execute-stage subsystem of the 5-stage MIPS pipeline
// ID/EX and EX/MEM registers around forwarding, hazard, ALU and next-PC logic
`timescale 1ns/1ps
`default_nettype none

module ex_stage_top import mips_pkg::*; (
	input  wire logic    clk,
	input  wire logic    arst_n,
	input  wire id_ex_t  id_in,
	input  wire wb_fwd_t wb_fwd,
	output logic         stall,
	output redirect_t    redirect,
	output ex_mem_t      ex_mem_out
);

	id_ex_t                ex_in;
	ex_mem_t               ex_next;
	logic                  insert_bubble;
	fwd_sel_e              fwd_a;
	fwd_sel_e              fwd_b;
	logic [data_w-1:0]     op_a;
	logic [data_w-1:0]     op_b;
	logic [data_w-1:0]     store_data;
	logic [reg_addr_w-1:0] dest;
	logic [data_w-1:0]     alu_result;
	logic                  alu_zero;

	// ID/EX, bubbled on load-use stall or redirect
	pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
		.clk    (clk),
		.arst_n (arst_n),
		.hold   (1'b0),
		.bubble (insert_bubble),
		.d      (id_in),
		.q      (ex_in)
	);

	hazard_unit u_hazard (
		.id_in          (id_in),
		.ex_in          (ex_in),
		.redirect_taken (redirect.taken),
		.stall          (stall),
		.insert_bubble  (insert_bubble)
	);

	// EX/MEM output doubles as the newer forwarding source
	forward_unit u_forward (
		.rs_addr (ex_in.rs),
		.rt_addr (ex_in.rt),
		.ex_mem  (ex_mem_out),
		.wb_fwd  (wb_fwd),
		.fwd_a   (fwd_a),
		.fwd_b   (fwd_b)
	);

	operand_select u_operand (
		.ex_in         (ex_in),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b),
		.ex_mem_result (ex_mem_out.result),
		.wb_data       (wb_fwd.data),
		.op_a          (op_a),
		.op_b          (op_b),
		.store_data    (store_data),
		.dest          (dest)
	);

	alu u_alu (
		.op_a      (op_a),
		.op_b      (op_b),
		.alu_op    (ex_in.ctrl.alu_op),
		.jal       (ex_in.ctrl.jal),
		.pc_plus_4 (ex_in.pc_plus_4),
		.result    (alu_result),
		.zero      (alu_zero)
	);

	// jr target is the forwarded rs, i.e. op_a
	next_pc_select u_next_pc (
		.ex_in    (ex_in),
		.rs_value (op_a),
		.zero     (alu_zero),
		.redirect (redirect)
	);

	// bubbles reach EX/MEM as cleared valid and enables
	assign ex_next = '{
		valid:      ex_in.valid,
		reg_write:  ex_in.ctrl.reg_write,
		mem_read:   ex_in.ctrl.mem_read,
		mem_write:  ex_in.ctrl.mem_write,
		mem_to_reg: ex_in.ctrl.mem_to_reg,
		dest:       dest,
		result:     alu_result,
		store_data: store_data
	};

	pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
		.clk    (clk),
		.arst_n (arst_n),
		.hold   (1'b0),
		.bubble (1'b0),
		.d      (ex_next),
		.q      (ex_mem_out)
	);

endmodule

`default_nettype wire

//--- next_pc_select.sv
// next-PC resolution in EX
// branch compare, jump target, jr, and the redirect to fetch
`timescale 1ns/1ps
`default_nettype none

module next_pc_select import mips_pkg::*; (
	input  wire id_ex_t            ex_in,
	input  wire logic [data_w-1:0] rs_value,
	input  wire logic              zero,
	output redirect_t              redirect
);

	logic [data_w-1:0] branch_target;
	logic [data_w-1:0] jump_target;
	logic              branch_taken;
	logic              is_jump;

	// word offset from the delay-free pc+4
	assign branch_target = ex_in.pc_plus_4 + {ex_in.imm[data_w-3:0], 2'b00};

	// pseudo-direct target from the top nibble of pc+4 and the word index
	assign jump_target = {ex_in.pc_plus_4[data_w-1:data_w-4], ex_in.jump_index, 2'b00};

	always_comb begin
		case (ex_in.ctrl.branch)
			br_beq:  branch_taken = zero;
			br_bne:  branch_taken = !zero;
			default: branch_taken = 1'b0;
		endcase
	end

	// jal redirects exactly like j
	assign is_jump = ex_in.ctrl.jump || ex_in.ctrl.jal;

	// jr first, then jump, then taken branch
	// no selection falls through to pc+4
	always_comb begin
		if (ex_in.ctrl.jr) begin
			redirect.target = rs_value;
		end else if (is_jump) begin
			redirect.target = jump_target;
		end else if (branch_taken) begin
			redirect.target = branch_target;
		end else begin
			redirect.target = ex_in.pc_plus_4;
		end
	end

	// a bubble never redirects
	assign redirect.taken = ex_in.valid && (ex_in.ctrl.jr || is_jump || branch_taken);

endmodule

`default_nettype wire

//--- alu.sv
// 32-bit ALU for the execute stage
// jal passes pc+4 through as its result so the link value can forward
`timescale 1ns/1ps
`default_nettype none

module alu import mips_pkg::*; (
	input  wire logic [data_w-1:0] op_a,
	input  wire logic [data_w-1:0] op_b,
	input  wire alu_op_e           alu_op,
	input  wire logic              jal,
	input  wire logic [data_w-1:0] pc_plus_4,
	output logic [data_w-1:0]      result,
	output logic                   zero
);

	logic [data_w-1:0] alu_out;
	logic              less;

	// slt compares as signed words
	assign less = $signed(op_a) < $signed(op_b);

	always_comb begin
		case (alu_op)
			alu_add: alu_out = op_a + op_b;
			alu_sub: alu_out = op_a - op_b;
			alu_and: alu_out = op_a & op_b;
			alu_or:  alu_out = op_a | op_b;
			alu_xor: alu_out = op_a ^ op_b;
			alu_nor: alu_out = ~(op_a | op_b);
			alu_slt: alu_out = {{(data_w-1){1'b0}}, less};
			default: alu_out = '0;
		endcase
	end

	// link value takes over the result for jal
	// writeback then treats it like any ALU result
	assign result = jal ? pc_plus_4 : alu_out;

	// equality of the two operands
	// independent of alu_op so beq/bne need no particular encoding
	assign zero = (op_a == op_b);

endmodule

`default_nettype wire

//--- operand_select.sv
// EX operand selection
// forwarding muxes, ALUSrc immediate choice and RegDst destination
`timescale 1ns/1ps
`default_nettype none

module operand_select import mips_pkg::*; (
	input  wire id_ex_t                ex_in,
	input  wire fwd_sel_e              fwd_a,
	input  wire fwd_sel_e              fwd_b,
	input  wire logic [data_w-1:0]     ex_mem_result,
	input  wire logic [data_w-1:0]     wb_data,
	output logic [data_w-1:0]          op_a,
	output logic [data_w-1:0]          op_b,
	output logic [data_w-1:0]          store_data,
	output logic [reg_addr_w-1:0]      dest
);

	logic [data_w-1:0] rt_value;

	// forward A picks the rs value
	always_comb begin
		case (fwd_a)
			fwd_ex_mem: op_a = ex_mem_result;
			fwd_mem_wb: op_a = wb_data;
			default:    op_a = ex_in.rs_data;
		endcase
	end

	// forward B picks the rt value
	always_comb begin
		case (fwd_b)
			fwd_ex_mem: rt_value = ex_mem_result;
			fwd_mem_wb: rt_value = wb_data;
			default:    rt_value = ex_in.rt_data;
		endcase
	end

	// immediate replaces rt for I-type ops
	assign op_b = ex_in.ctrl.alu_src ? ex_in.imm : rt_value;

	// a store writes the forwarded rt, never the immediate
	assign store_data = rt_value;

	always_comb begin
		case (ex_in.ctrl.reg_dst)
			reg_dst_rd: dest = ex_in.rd;
			// jal links into $ra
			reg_dst_ra: dest = ra_reg;
			default:    dest = ex_in.rt;
		endcase
	end

endmodule

`default_nettype wire

//--- forward_unit.sv
// forwarding unit
// picks the source of each EX operand from EX/MEM, MEM/WB or the register file
`timescale 1ns/1ps
`default_nettype none

module forward_unit import mips_pkg::*; (
	input  wire logic [reg_addr_w-1:0] rs_addr,
	input  wire logic [reg_addr_w-1:0] rt_addr,
	input  wire ex_mem_t               ex_mem,
	input  wire wb_fwd_t               wb_fwd,
	output fwd_sel_e                   fwd_a,
	output fwd_sel_e                   fwd_b
);

	logic ex_ok;
	logic wb_ok;

	// a load in EX/MEM has no data yet
	// the hazard unit stalls that case instead
	assign ex_ok = ex_mem.reg_write && !ex_mem.mem_read && (ex_mem.dest != '0);

	// nonzero dest keeps $zero from ever being forwarded
	assign wb_ok = wb_fwd.reg_write && (wb_fwd.dest != '0);

	// the newer value in EX/MEM wins over MEM/WB
	always_comb begin
		fwd_a = fwd_reg;
		if (ex_ok && (ex_mem.dest == rs_addr)) begin
			fwd_a = fwd_ex_mem;
		end else if (wb_ok && (wb_fwd.dest == rs_addr)) begin
			fwd_a = fwd_mem_wb;
		end
	end

	always_comb begin
		fwd_b = fwd_reg;
		if (ex_ok && (ex_mem.dest == rt_addr)) begin
			fwd_b = fwd_ex_mem;
		end else if (wb_ok && (wb_fwd.dest == rt_addr)) begin
			fwd_b = fwd_mem_wb;
		end
	end

endmodule

`default_nettype wire

//--- hazard_unit.sv
// load-use hazard detection
// decides stall and bubble insertion for the ID/EX register
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import mips_pkg::*; (
	input  wire id_ex_t id_in,
	input  wire id_ex_t ex_in,
	input  wire logic   redirect_taken,
	output logic        stall,
	output logic        insert_bubble
);

	logic load_use;

	// a load writes rt
	// the value is not ready until after MEM, so a reader right behind it must wait
	assign load_use = ex_in.valid
		&& ex_in.ctrl.mem_read
		&& (ex_in.rt != '0)
		&& ((ex_in.rt == id_in.rs) || (ex_in.rt == id_in.rt));

	// on a redirect id_in is wrong-path
	// drop it instead of holding it
	assign stall = load_use && !redirect_taken;

	// either case puts a bubble into EX next cycle
	assign insert_bubble = load_use || redirect_taken;

endmodule

`default_nettype wire

//--- pipe_reg.sv
// pipeline register for any packed payload
// holds on request, loads an all-zero bubble when asked
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  wire logic     clk,
	input  wire logic     arst_n,
	input  wire logic     hold,
	input  wire logic     bubble,
	input  wire payload_t d,
	output payload_t      q
);

	// bubble outranks hold
	// an all-zero payload has valid and every enable low
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			q <= '0;
		end else if (bubble) begin
			q <= '0;
		end else if (!hold) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

//--- mips_pkg.sv
// MIPS execute-stage shared definitions
// control word, pipeline bundles, forwarding and redirect types
`default_nettype none

package mips_pkg;

	// datapath widths
	localparam int data_w = 32;
	localparam int reg_addr_w = 5;
	// $ra, written by jal
	localparam logic [reg_addr_w-1:0] ra_reg = 5'd31;

	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_xor = 3'd4,
		alu_nor = 3'd5,
		alu_slt = 3'd6
	} alu_op_e;

	// rt for immediate types, rd for r-type, ra for jal
	typedef enum logic [1:0] {
		reg_dst_rt = 2'd0,
		reg_dst_rd = 2'd1,
		reg_dst_ra = 2'd2
	} reg_dst_e;

	// operand source chosen by the forwarding unit
	typedef enum logic [1:0] {
		fwd_reg    = 2'd0,
		fwd_ex_mem = 2'd1,
		fwd_mem_wb = 2'd2
	} fwd_sel_e;

	typedef enum logic [1:0] {
		br_none = 2'd0,
		br_beq  = 2'd1,
		br_bne  = 2'd2
	} branch_e;

	typedef struct packed {
		logic     reg_write;
		logic     mem_read;
		logic     mem_write;
		logic     mem_to_reg;
		logic     alu_src;
		reg_dst_e reg_dst;
		alu_op_e  alu_op;
		branch_e  branch;
		logic     jump;
		logic     jal;
		logic     jr;
	} ctrl_t;

	// decoded instruction as it sits in ID/EX
	typedef struct packed {
		logic                  valid;
		ctrl_t                 ctrl;
		logic [data_w-1:0]     pc_plus_4;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
		logic [reg_addr_w-1:0] rd;
		logic [data_w-1:0]     rs_data;
		logic [data_w-1:0]     rt_data;
		// already sign-extended
		logic [data_w-1:0]     imm;
		logic [25:0]           jump_index;
	} id_ex_t;

	typedef struct packed {
		logic                  valid;
		logic                  reg_write;
		logic                  mem_read;
		logic                  mem_write;
		logic                  mem_to_reg;
		logic [reg_addr_w-1:0] dest;
		logic [data_w-1:0]     result;
		logic [data_w-1:0]     store_data;
	} ex_mem_t;

	// writeback value seen by the forwarding unit
	typedef struct packed {
		logic                  reg_write;
		logic [reg_addr_w-1:0] dest;
		logic [data_w-1:0]     data;
	} wb_fwd_t;

	typedef struct packed {
		logic              taken;
		logic [data_w-1:0] target;
	} redirect_t;

endpackage

`default_nettype wire
